/* filelist.f */
verilog/lcdPkg.sv
verilog/lcdByteIf.sv
verilog/lcdWbRegs.sv
verilog/lcdSequencer.sv
verilog/lcdBusWriter.sv
verilog/lcdCtrlTop.sv
tb/lcdCtrlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the TFT controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module lcdCtrlTb -o lcdSim

out=$(./obj_dir/lcdSim)
echo "$out"
echo "$out" | grep -q "Test completed successfully"

/* tb/lcdCtrlTb.sv */
`timescale 1ns/1ps

module lcdCtrlTb;
    import lcdPkg::*;

    localparam int waitSum = int'(waitReset) + 2 * int'(waitSleepOut)
                             + int'(waitDispOn) + int'(waitSleepIn);
    localparam int expBytes = 44;
    localparam int wbAccesses = 30;
    localparam int opCount = 9;
    // each access, byte and settle period counted twice plus slack.
    localparam int timeoutCycles =
        2 * (waitSum + 4 * expBytes + 4 * wbAccesses + 8 * opCount) + 200;

    logic        clk;
    logic        rst;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [2:0]  wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;
    logic        opDone;
    logic        csx;
    logic        dcx;
    logic        wrx;
    logic [7:0]  data;

    lcdByte_t    seenQ[$];
    lcdByte_t    expQ[$];
    lcdByte_t    lastSeen;
    int          fallAt[$];
    int          riseAt[$];
    int          frames = 0;
    int          cycles = 0;
    int          doneCnt = 0;
    int          doneBase = 0;
    int          byteErrs = 0;
    int          wordErrs = 0;
    int          gapErrs = 0;
    int          otherErrs = 0;
    logic [31:0] rngState = 32'd720;

    lcdCtrlTop u_lcdCtrlTop (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .opDone (opDone),
        .csx    (csx),
        .dcx    (dcx),
        .wrx    (wrx),
        .data   (data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the panel latches on the rising wrx.
    always @(posedge wrx) begin
        if (!rst) begin
            seenQ.push_back('{isData: dcx, value: data, last: 1'b0});
            riseAt.push_back(cycles);
        end
    end

    always @(negedge wrx) begin
        if (!rst) begin
            fallAt.push_back(cycles);
        end
    end

    always @(negedge csx) begin
        if (!rst) begin
            frames++;
        end
    end

    always @(posedge csx) begin
        if (!rst && seenQ.size() > 0) begin
            lastSeen = seenQ.pop_back();
            lastSeen.last = 1'b1;  // frame closed on this byte.
            seenQ.push_back(lastSeen);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (opDone) begin
            doneCnt++;
        end
        if (cycles > timeoutCycles) begin
            otherErrs++;
            $display("timeout: run still going after %0d cycles", cycles);
            printCounts();
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic printCounts();
        $display("errors: byte %0d, word %0d, gap %0d, other %0d",
                 byteErrs, wordErrs, gapErrs, otherErrs);
    endtask

    task automatic checkByte(input lcdByte_t got, input lcdByte_t exp, input string name);
        if (got !== exp) begin
            byteErrs++;
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp,
                             input string name);
        if (got !== exp) begin
            wordErrs++;
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkGap(input int got, input int least, input string name);
        if (got < least) begin
            gapErrs++;
            $display("ERROR %s: got 0x%h expected at least 0x%h", name, got, least);
        end
    endtask

    task automatic wbAccess(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        @(negedge clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdat;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        rdat = wbDatR;
        @(negedge clk);  // strobe held over the ack edge.
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbWrite(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wbAccess(1'b1, adr, wdat, unused);
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [31:0] rdat);
        wbAccess(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic startOp(input lcdOp_t op);
        doneBase = doneCnt;
        wbWrite(adrCtrl, {29'd0, op});
    endtask

    task automatic waitDone(input string name);
        while (doneCnt == doneBase) @(negedge clk);
        repeat (8) @(negedge clk);
        if (doneCnt != doneBase + 1) begin
            otherErrs++;
            $display("%s: opDone pulsed %0d times instead of once", name, doneCnt - doneBase);
        end
    endtask

    task automatic runOp(input lcdOp_t op, input string name);
        startOp(op);
        waitDone(name);
    endtask

    task automatic addByte(input logic isData, input logic [7:0] value);
        expQ.push_back('{isData: isData, value: value, last: 1'b0});
    endtask

    task automatic addWindow(input logic [7:0] cmd, input logic [31:0] word);
        addByte(1'b0, cmd);
        for (int i = 3; i >= 0; i--) begin
            addByte(1'b1, word[8*i +: 8]);
        end
    endtask

    task automatic addFill(input logic [15:0] color, input int count);
        addByte(1'b0, cmdMemWrite);
        for (int i = 0; i < count; i++) begin
            addByte(1'b1, color[15:8]);
            addByte(1'b1, color[7:0]);
        end
    endtask

    task automatic compareFrame(input string name);
        lcdByte_t tail;
        tail = expQ.pop_back();
        tail.last = 1'b1;
        expQ.push_back(tail);
        if (seenQ.size() != expQ.size()) begin
            otherErrs++;
            $display("%s: panel saw %0d bytes, %0d expected", name, seenQ.size(), expQ.size());
        end else begin
            for (int i = 0; i < expQ.size(); i++) begin
                checkByte(seenQ[i], expQ[i], $sformatf("{dcx,data} %s byte %0d", name, i));
            end
        end
        if (frames != 1) begin
            otherErrs++;
            $display("%s: %0d chip select frames instead of one", name, frames);
        end
        seenQ.delete();
        expQ.delete();
        fallAt.delete();
        riseAt.delete();
        frames = 0;
    endtask

    task automatic testWindows();
        logic [31:0] colW;
        logic [31:0] pageW;
        colW = nextRandom();
        pageW = nextRandom();
        wbWrite(adrColumn, colW);
        wbWrite(adrPage, pageW);
        runOp(opColumn, "column");
        addWindow(cmdColumn, colW);
        compareFrame("column");
        runOp(opPage, "page");
        addWindow(cmdPage, pageW);
        compareFrame("page");
    endtask

    task automatic testFill();
        logic [15:0] color;
        color = 16'(nextRandom() >> 16);
        wbWrite(adrColor, {16'd0, color});
        wbWrite(adrCount, 32'd5);
        runOp(opFill, "fill");
        addFill(color, 5);
        compareFrame("fill");
        wbWrite(adrCount, 32'd0);
        runOp(opFill, "empty fill");
        addFill(color, 0);
        compareFrame("empty fill");
    endtask

    task automatic testInit();
        runOp(opInit, "init");
        if (fallAt.size() < 3 || riseAt.size() < 2) begin
            otherErrs++;
            $display("init: too few write strobes to measure the waits");
        end else begin
            checkGap(fallAt[1] - riseAt[0], int'(waitReset), "wrx gap after reset");
            checkGap(fallAt[2] - riseAt[1], int'(waitSleepOut), "wrx gap after sleep out");
        end
        addByte(1'b0, cmdSwReset);
        addByte(1'b0, cmdSleepOut);
        addByte(1'b0, cmdPixFmt);
        addByte(1'b1, parPixFmt);
        addByte(1'b0, cmdMadctl);
        addByte(1'b1, parMadctl);
        addByte(1'b0, cmdDispOn);
        compareFrame("init");
    endtask

    task automatic testSleepWake();
        runOp(opSleep, "sleep");
        addByte(1'b0, cmdDispOff);
        addByte(1'b0, cmdSleepIn);
        compareFrame("sleep");
        runOp(opWake, "wake");
        addByte(1'b0, cmdSleepOut);
        addByte(1'b0, cmdDispOn);
        compareFrame("wake");
    endtask

    task automatic testRegisters();
        logic [31:0] colW;
        logic [31:0] pageW;
        logic [31:0] colorW;
        logic [31:0] countW;
        logic [31:0] rd;
        colW = nextRandom();
        pageW = nextRandom();
        colorW = nextRandom() & 32'h0000_ffff;
        countW = nextRandom() & 32'h0001_ffff;
        wbWrite(adrColumn, colW);
        wbWrite(adrPage, pageW);
        wbWrite(adrColor, colorW);
        wbWrite(adrCount, countW);
        wbRead(adrColumn, rd);
        checkWord(rd, colW, "wbDatR column");
        wbRead(adrPage, rd);
        checkWord(rd, pageW, "wbDatR page");
        wbRead(adrColor, rd);
        checkWord(rd, colorW, "wbDatR color");
        wbRead(adrCount, rd);
        checkWord(rd, countW, "wbDatR count");
        wbWrite(adrCount, 32'd4);
        startOp(opFill);
        wbRead(adrCtrl, rd);
        checkWord(rd, 32'd1, "wbDatR status while busy");
        wbWrite(adrCtrl, {29'd0, opFill});  // ignored while busy.
        waitDone("busy fill");
        repeat (10) @(negedge clk);
        wbRead(adrCtrl, rd);
        checkWord(rd, 32'd0, "wbDatR status when idle");
        addFill(colorW[15:0], 4);
        compareFrame("busy fill");
    endtask

    initial begin
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = 3'd0;
        wbDatW = 32'd0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        testWindows();
        testFill();
        testInit();
        testSleepWake();
        testRegisters();
        printCounts();
        if (byteErrs + wordErrs + gapErrs + otherErrs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/lcdCtrlTop.sv */
`timescale 1ns/1ps

module lcdCtrlTop (
    input  logic        clk,
    input  logic        rst,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [2:0]  wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck,
    output logic        opDone,
    output logic        csx,
    output logic        dcx,
    output logic        wrx,
    output logic [7:0]  data
);
    import lcdPkg::*;

    lcdJob_t job;
    logic    start;
    logic    busy;
    logic    frameEnd;

    lcdByteIf byteLink ();

    lcdWbRegs uWbRegs (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .job    (job),
        .start  (start),
        .busy   (busy)
    );

    lcdSequencer uSequencer (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .job      (job),
        .frameEnd (frameEnd),
        .busy     (busy),
        .done     (opDone),
        .bytes    (byteLink.source)
    );

    lcdBusWriter uBusWriter (
        .clk      (clk),
        .rst      (rst),
        .bytes    (byteLink.sink),
        .frameEnd (frameEnd),
        .csx      (csx),
        .dcx      (dcx),
        .wrx      (wrx),
        .data     (data)
    );

endmodule

/* verilog/lcdBusWriter.sv */
`timescale 1ns/1ps

module lcdBusWriter (
    input  logic       clk,
    input  logic       rst,
    lcdByteIf.sink     bytes,
    output logic       frameEnd,
    output logic       csx,
    output logic       dcx,
    output logic       wrx,
    output logic [7:0] data
);
    import lcdPkg::*;

    typedef enum logic [1:0] {
        wIdle,
        wOpen,
        wLow,
        wHigh
    } wrState_t;

    wrState_t state;
    lcdByte_t hold;
    logic     accept;

    assign bytes.ready = (state == wIdle);
    assign accept = bytes.valid && bytes.ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            hold <= bytes.item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= wIdle;
            csx      <= 1'b1;
            dcx      <= 1'b1;
            wrx      <= 1'b1;
            data     <= 8'h00;
            frameEnd <= 1'b0;
        end else begin
            frameEnd <= 1'b0;
            case (state)
                wIdle: begin
                    if (accept) begin
                        if (csx) begin
                            csx   <= 1'b0;  // open the frame first.
                            state <= wOpen;
                        end else begin
                            wrx   <= 1'b0;
                            dcx   <= bytes.item.isData;
                            data  <= bytes.item.value;
                            state <= wLow;
                        end
                    end
                end
                wOpen: begin
                    wrx   <= 1'b0;
                    dcx   <= hold.isData;
                    data  <= hold.value;
                    state <= wLow;
                end
                wLow: begin
                    wrx   <= 1'b1;  // panel latches here.
                    state <= wHigh;
                end
                wHigh: begin
                    if (hold.last) begin
                        csx      <= 1'b1;
                        frameEnd <= 1'b1;
                    end
                    state <= wIdle;
                end
                default: state <= wIdle;
            endcase
        end
    end

    strobeInFrame: assert property (
        @(posedge clk) disable iff (rst) !wrx |-> !csx
    );

endmodule

/* verilog/lcdSequencer.sv */
`timescale 1ns/1ps

module lcdSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  lcdPkg::lcdJob_t job,
    input  logic            frameEnd,
    output logic            busy,
    output logic            done,
    lcdByteIf.source        bytes
);
    import lcdPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stSend,
        stWait,
        stPix,
        stClose
    } seqState_t;

    seqState_t   state;
    logic [2:0]  step;
    logic [15:0] waitCnt;
    logic [16:0] pixLeft;
    logic        lowHalf;
    logic        closed;
    logic        accept;

    lcdByte_t    scrByte;
    logic [15:0] scrWait;
    lcdByte_t    pixByte;
    logic [31:0] winWord;
    logic [7:0]  winCmd;

    function automatic lcdByte_t mkByte(
        input logic       isDat,
        input logic [7:0] val,
        input logic       lst
    );
        mkByte = '{isData: isDat, value: val, last: lst};
    endfunction

    assign accept = bytes.valid && bytes.ready;
    assign winWord = (job.op == opColumn) ? job.column : job.page;
    assign winCmd = (job.op == opColumn) ? cmdColumn : cmdPage;

    // byte list per operation with the pause that follows each byte.
    always_comb begin
        scrByte = mkByte(1'b0, 8'h00, 1'b1);  // nop.
        scrWait = 16'd0;
        case (job.op)
            opInit: begin
                case (step)
                    3'd0: begin
                        scrByte = mkByte(1'b0, cmdSwReset, 1'b0);
                        scrWait = waitReset;
                    end
                    3'd1: begin
                        scrByte = mkByte(1'b0, cmdSleepOut, 1'b0);
                        scrWait = waitSleepOut;
                    end
                    3'd2: scrByte = mkByte(1'b0, cmdPixFmt, 1'b0);
                    3'd3: scrByte = mkByte(1'b1, parPixFmt, 1'b0);
                    3'd4: scrByte = mkByte(1'b0, cmdMadctl, 1'b0);
                    3'd5: scrByte = mkByte(1'b1, parMadctl, 1'b0);
                    default: scrByte = mkByte(1'b0, cmdDispOn, 1'b1);
                endcase
            end
            opSleep: begin
                if (step == 3'd0) begin
                    scrByte = mkByte(1'b0, cmdDispOff, 1'b0);
                    scrWait = waitDispOn;
                end else begin
                    scrByte = mkByte(1'b0, cmdSleepIn, 1'b1);
                    scrWait = waitSleepIn;  // held busy until the panel settles.
                end
            end
            opWake: begin
                if (step == 3'd0) begin
                    scrByte = mkByte(1'b0, cmdSleepOut, 1'b0);
                    scrWait = waitSleepOut;
                end else begin
                    scrByte = mkByte(1'b0, cmdDispOn, 1'b1);
                end
            end
            opColumn, opPage: begin
                case (step)
                    3'd0: scrByte = mkByte(1'b0, winCmd, 1'b0);
                    3'd1: scrByte = mkByte(1'b1, winWord[31:24], 1'b0);
                    3'd2: scrByte = mkByte(1'b1, winWord[23:16], 1'b0);
                    3'd3: scrByte = mkByte(1'b1, winWord[15:8], 1'b0);
                    default: scrByte = mkByte(1'b1, winWord[7:0], 1'b1);
                endcase
            end
            opFill: scrByte = mkByte(1'b0, cmdMemWrite, job.count == 17'd0);
            default: ;
        endcase
    end

    assign pixByte = mkByte(1'b1, lowHalf ? job.color[7:0] : job.color[15:8],
                            lowHalf && (pixLeft == 17'd1));

    assign bytes.valid = (state == stSend) || (state == stPix);
    assign bytes.item = (state == stPix) ? pixByte : scrByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            busy    <= 1'b0;
            done    <= 1'b0;
            step    <= 3'd0;
            waitCnt <= 16'd0;
            pixLeft <= 17'd0;
            lowHalf <= 1'b0;
            closed  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        state   <= stSend;
                        busy    <= 1'b1;
                        step    <= 3'd0;
                        pixLeft <= job.count;
                        lowHalf <= 1'b0;
                        closed  <= 1'b0;
                    end
                end
                stSend: begin
                    if (accept) begin
                        if (scrByte.last) begin
                            waitCnt <= scrWait;
                            state   <= stClose;
                        end else if (job.op == opFill) begin
                            state <= stPix;
                        end else begin
                            step <= step + 3'd1;
                            if (scrWait != 16'd0) begin
                                waitCnt <= scrWait;  // counted from acceptance.
                                state   <= stWait;
                            end
                        end
                    end
                end
                stWait: begin
                    if (waitCnt == 16'd0) begin
                        state <= stSend;
                    end else begin
                        waitCnt <= waitCnt - 16'd1;
                    end
                end
                stPix: begin
                    if (accept) begin
                        lowHalf <= !lowHalf;
                        if (lowHalf) begin
                            pixLeft <= pixLeft - 17'd1;
                            if (pixLeft == 17'd1) begin
                                waitCnt <= 16'd0;
                                state   <= stClose;
                            end
                        end
                    end
                end
                stClose: begin
                    if (frameEnd) begin
                        closed <= 1'b1;
                    end
                    if (waitCnt != 16'd0) begin
                        waitCnt <= waitCnt - 16'd1;
                    end else if (closed || frameEnd) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    noStartWhileBusy: assert property (
        @(posedge clk) disable iff (rst) start |-> !busy
    );

endmodule

/* verilog/lcdWbRegs.sv */
`timescale 1ns/1ps

module lcdWbRegs (
    input  logic            clk,
    input  logic            rst,
    input  logic            wbCyc,
    input  logic            wbStb,
    input  logic            wbWe,
    input  logic [2:0]      wbAdr,
    input  logic [31:0]     wbDatW,
    output logic [31:0]     wbDatR,
    output logic            wbAck,
    output lcdPkg::lcdJob_t job,
    output logic            start,
    input  logic            busy
);
    import lcdPkg::*;

    logic        req;
    logic        opValid;
    logic        launch;
    logic        statusBusy;
    logic [31:0] rdData;

    logic [31:0] colReg;
    logic [31:0] pageReg;
    logic [15:0] colorReg;
    logic [16:0] countReg;

    lcdOp_t      jobOp;
    logic [31:0] jobCol;
    logic [31:0] jobPage;
    logic [15:0] jobColor;
    logic [16:0] jobCount;

    assign req = wbCyc && wbStb && !wbAck;  // one ack per request.
    assign opValid = (wbDatW[2:0] >= 3'(opInit)) && (wbDatW[2:0] <= 3'(opFill));
    assign statusBusy = busy || start;
    assign launch = req && wbWe && (wbAdr == adrCtrl) && opValid && !statusBusy;

    assign job = '{
        op:     jobOp,
        column: jobCol,
        page:   jobPage,
        color:  jobColor,
        count:  jobCount
    };

    always_comb begin
        case (wbAdr)
            adrCtrl:   rdData = {31'd0, statusBusy};
            adrColumn: rdData = colReg;
            adrPage:   rdData = pageReg;
            adrColor:  rdData = {16'd0, colorReg};
            adrCount:  rdData = {15'd0, countReg};
            default:   rdData = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            start <= 1'b0;
            jobOp <= opNone;
        end else begin
            wbAck <= req;
            start <= launch;
            if (launch) begin
                jobOp <= lcdOp_t'(wbDatW[2:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && wbWe) begin
            case (wbAdr)
                adrColumn: colReg <= wbDatW;
                adrPage:   pageReg <= wbDatW;
                adrColor:  colorReg <= wbDatW[15:0];
                adrCount:  countReg <= wbDatW[16:0];
                default: ;
            endcase
        end
        if (req) begin
            wbDatR <= rdData;
        end
        if (launch) begin  // snapshot so later writes do not disturb a running job.
            jobCol   <= colReg;
            jobPage  <= pageReg;
            jobColor <= colorReg;
            jobCount <= countReg;
        end
    end

    ackInsideStrobe: assert property (
        @(posedge clk) disable iff (rst) wbAck |-> wbStb
    );

endmodule

/* verilog/lcdByteIf.sv */
`timescale 1ns/1ps

interface lcdByteIf;
    import lcdPkg::*;

    logic     valid;
    logic     ready;
    lcdByte_t item;

    modport source (
        output valid,
        output item,
        input  ready
    );

    modport sink (
        input  valid,
        input  item,
        output ready
    );

endinterface

/* verilog/lcdPkg.sv */
package lcdPkg;

    typedef enum logic [2:0] {
        opNone   = 3'd0,
        opInit   = 3'd1,
        opSleep  = 3'd2,
        opWake   = 3'd3,
        opColumn = 3'd4,
        opPage   = 3'd5,
        opFill   = 3'd6
    } lcdOp_t;

    typedef struct packed {
        lcdOp_t      op;
        logic [31:0] column;  // xs high, xs low, xe high, xe low.
        logic [31:0] page;
        logic [15:0] color;   // rgb565.
        logic [16:0] count;
    } lcdJob_t;

    typedef struct packed {
        logic       isData;
        logic [7:0] value;
        logic       last;     // closes the csx frame.
    } lcdByte_t;

    localparam logic [7:0] cmdSwReset  = 8'h01;
    localparam logic [7:0] cmdSleepIn  = 8'h10;
    localparam logic [7:0] cmdSleepOut = 8'h11;
    localparam logic [7:0] cmdDispOff  = 8'h28;
    localparam logic [7:0] cmdDispOn   = 8'h29;
    localparam logic [7:0] cmdColumn   = 8'h2A;
    localparam logic [7:0] cmdPage     = 8'h2B;
    localparam logic [7:0] cmdMemWrite = 8'h2C;
    localparam logic [7:0] cmdMadctl   = 8'h36;
    localparam logic [7:0] cmdPixFmt   = 8'h3A;

    localparam logic [7:0] parMadctl = 8'h30;
    localparam logic [7:0] parPixFmt = 8'h55;  // 16 bits per pixel.

    // panel delays shortened to a few dozen clocks.
    localparam logic [15:0] waitReset    = 16'd40;
    localparam logic [15:0] waitSleepOut = 16'd60;
    localparam logic [15:0] waitSleepIn  = 16'd30;
    localparam logic [15:0] waitDispOn   = 16'd20;

    localparam logic [2:0] adrCtrl   = 3'd0;
    localparam logic [2:0] adrColumn = 3'd1;
    localparam logic [2:0] adrPage   = 3'd2;
    localparam logic [2:0] adrColor  = 3'd3;
    localparam logic [2:0] adrCount  = 3'd4;

endpackage
